//--- adapter_pkg.sv
`default_nettype none

package adapter_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] paddr_t;
  typedef logic [63:0] word_t;
  typedef logic [7:0]  strb_t;
  typedef logic [3:0]  tid_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  blen_t;
  typedef logic        bus_id_t;

  // line lengths in bus words
  localparam int unsigned ICACHE_LINE_WORDS = 4;
  localparam int unsigned DCACHE_LINE_WORDS = 2;

  // bus id per cache
  localparam bus_id_t ID_ICACHE = 1'b0;
  localparam bus_id_t ID_DCACHE = 1'b1;

  typedef enum logic {
    DCACHE_LOAD,
    DCACHE_STORE
  } dcache_req_e;

  typedef enum logic {
    DCACHE_LOAD_ACK,
    DCACHE_STORE_ACK
  } dcache_ack_e;

  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_e;

  // strobes for one access, aligned to its natural size
  function automatic strb_t to_byte_enable(input logic [2:0] off, input logic [1:0] size);
    strb_t be;
    case (size)
      2'b00:   be = strb_t'(8'h01) << off;
      2'b01:   be = strb_t'(8'h03) << {off[2:1], 1'b0};
      2'b10:   be = strb_t'(8'h0f) << {off[2], 2'b00};
      default: be = 8'hff;
    endcase
    return be;
  endfunction

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [PtrW:0]    count_q;

  assign full_o  = (count_q == (PtrW+1)'(Depth));
  assign empty_o = (count_q == '0);
  // head of queue shows without a pop
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  // callers must honour the flags
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- line_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module line_assembler import adapter_pkg::*; #(
  parameter int unsigned LineWords = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    beat_en_i,
  input  word_t                   beat_data_i,
  input  logic                    beat_last_i,
  output word_t [LineWords-1:0]   line_o
);

  word_t [LineWords-1:0] line_q;
  logic                  first_q;

  assign line_o = line_q;

  // set again by the last beat, so the next transaction starts clean
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
    end else if (beat_en_i) begin
      first_q <= beat_last_i;
    end
  end

  ////////////////////
  // beat shift register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (beat_en_i) begin
      line_q <= {beat_data_i, line_q[LineWords-1:1]};
      // single word reads must end up at word 0
      if (first_q) begin
        line_q[0] <= beat_data_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- adapter_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module adapter_ctrl import adapter_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // request and id queue status
  input  logic        icache_empty_i,
  input  logic        dcache_empty_i,
  input  logic        icache_id_full_i,
  input  logic        dcache_rd_id_full_i,
  input  logic        dcache_wr_id_full_i,
  input  logic        dcache_wr_id_empty_i,
  // queue heads
  input  paddr_t      icache_paddr_i,
  input  paddr_t      dcache_paddr_i,
  input  logic        icache_nc_i,
  input  dcache_req_e dcache_rtype_i,
  input  size_t       dcache_size_i,
  input  word_t       dcache_data_i,
  // queue control
  output logic        icache_pop_o,
  output logic        dcache_pop_o,
  output logic        icache_id_push_o,
  output logic        dcache_rd_id_push_o,
  output logic        dcache_wr_id_push_o,
  output logic        icache_id_pop_o,
  output logic        dcache_rd_id_pop_o,
  output logic        dcache_wr_id_pop_o,
  // read address
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  output paddr_t      ar_addr_o,
  output blen_t       ar_len_o,
  output logic [1:0]  ar_size_o,
  output bus_id_t     ar_id_o,
  // write address and data
  output logic        aw_valid_o,
  input  logic        aw_ready_i,
  output paddr_t      aw_addr_o,
  output logic [1:0]  aw_size_o,
  output word_t       w_data_o,
  output strb_t       w_strb_o,
  // read data, never stalled
  input  logic        r_valid_i,
  input  logic        r_last_i,
  input  bus_id_t     r_id_i,
  // write response
  input  logic        b_valid_i,
  input  bus_id_t     b_id_i,
  output logic        b_ready_o,
  // return path
  output logic        icache_beat_en_o,
  output logic        dcache_beat_en_o,
  output logic        icache_rtrn_vld_o,
  output logic        dcache_rtrn_vld_o,
  output dcache_ack_e dcache_rtrn_type_o,
  output logic        dcache_rtrn_is_wr_o
);

  arb_state_e  arb_state_q;
  logic        arb_idx_q;
  logic        rr_q;
  logic        ic_comp;
  logic        dc_comp;
  logic        arb_idx;
  logic        req_vld;
  logic        is_store;
  logic        ar_fire;
  logic        aw_fire;
  logic        b_fire;
  logic        icache_rtrn_vld_q;
  logic        dcache_rtrn_vld_q;
  dcache_ack_e dcache_rtrn_type_q;

  ////////////////////
  // arbitration
  ////////////////////

  assign ic_comp = !icache_empty_i && !icache_id_full_i;
  assign dc_comp = !dcache_empty_i && !dcache_rd_id_full_i && !dcache_wr_id_full_i;

  // rr_q names the side that wins a tie
  always_comb begin
    if (arb_state_q == ARB_LOCKED) begin
      arb_idx = arb_idx_q;
    end else if (ic_comp && dc_comp) begin
      arb_idx = rr_q;
    end else begin
      arb_idx = dc_comp;
    end
  end

  assign req_vld  = (arb_state_q == ARB_LOCKED) || ic_comp || dc_comp;
  assign is_store = arb_idx && (dcache_rtype_i == DCACHE_STORE);
  assign ar_fire  = ar_valid_o && ar_ready_i;
  assign aw_fire  = aw_valid_o && aw_ready_i;

  assign icache_pop_o        = ar_fire && !arb_idx;
  assign dcache_pop_o        = (ar_fire || aw_fire) && arb_idx;
  assign icache_id_push_o    = ar_fire && !arb_idx;
  assign dcache_rd_id_push_o = ar_fire && arb_idx;
  assign dcache_wr_id_push_o = aw_fire;

  ////////////////////
  // request decode
  ////////////////////

  assign ar_valid_o = req_vld && !is_store;
  assign aw_valid_o = req_vld && is_store;

  always_comb begin
    if (arb_idx) begin
      ar_addr_o = dcache_paddr_i;
      ar_size_o = dcache_size_i[1:0];
      ar_id_o   = ID_DCACHE;
      ar_len_o  = dcache_size_i[2] ? blen_t'(DCACHE_LINE_WORDS - 1) : '0;
    end else begin
      // refills always fetch full bus words
      ar_addr_o = icache_paddr_i;
      ar_size_o = 2'b11;
      ar_id_o   = ID_ICACHE;
      ar_len_o  = icache_nc_i ? '0 : blen_t'(ICACHE_LINE_WORDS - 1);
    end
  end

  // stores are single beats
  assign aw_addr_o = dcache_paddr_i;
  assign aw_size_o = dcache_size_i[1:0];
  assign w_data_o  = dcache_data_i;
  assign w_strb_o  = to_byte_enable(dcache_paddr_i[2:0], dcache_size_i[1:0]);

  ////////////////////
  // return decode
  ////////////////////

  assign icache_beat_en_o = r_valid_i && (r_id_i == ID_ICACHE);
  assign dcache_beat_en_o = r_valid_i && (r_id_i == ID_DCACHE);

  // read beats win over write responses
  assign b_ready_o = !dcache_beat_en_o && !dcache_wr_id_empty_i;
  assign b_fire    = b_valid_i && b_ready_o && (b_id_i == ID_DCACHE);

  assign icache_id_pop_o     = icache_beat_en_o && r_last_i;
  assign dcache_rd_id_pop_o  = dcache_beat_en_o && r_last_i;
  assign dcache_wr_id_pop_o  = b_fire;
  assign dcache_rtrn_is_wr_o = b_fire;

  assign icache_rtrn_vld_o  = icache_rtrn_vld_q;
  assign dcache_rtrn_vld_o  = dcache_rtrn_vld_q;
  assign dcache_rtrn_type_o = dcache_rtrn_type_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arb_state_q        <= ARB_IDLE;
      arb_idx_q          <= 1'b0;
      rr_q               <= 1'b0;
      icache_rtrn_vld_q  <= 1'b0;
      dcache_rtrn_vld_q  <= 1'b0;
      dcache_rtrn_type_q <= DCACHE_LOAD_ACK;
    end else begin
      // hold the choice until the bus takes it
      if (ar_fire || aw_fire) begin
        arb_state_q <= ARB_IDLE;
        rr_q        <= !arb_idx;
      end else if (req_vld) begin
        arb_state_q <= ARB_LOCKED;
        arb_idx_q   <= arb_idx;
      end
      icache_rtrn_vld_q  <= icache_id_pop_o;
      dcache_rtrn_vld_q  <= dcache_rd_id_pop_o || b_fire;
      dcache_rtrn_type_q <= b_fire ? DCACHE_STORE_ACK : DCACHE_LOAD_ACK;
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  a_ar_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o)
      && $stable(ar_size_o) && $stable(ar_id_o));

  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_size_o)
      && $stable(w_data_o) && $stable(w_strb_o));

  // a store ack always pairs with an outstanding write id
  a_store_ack_has_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_rtrn_vld_o && dcache_rtrn_type_o == DCACHE_STORE_ACK
      |-> $past(!dcache_wr_id_empty_i));

endmodule

`default_nettype wire

//--- cache_bus_adapter.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bus_adapter import adapter_pkg::*; #(
  parameter int unsigned ReqFifoDepth  = 2,
  parameter int unsigned MetaFifoDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // icache
  input  logic                          icache_req_i,
  output logic                          icache_ack_o,
  input  paddr_t                        icache_paddr_i,
  input  logic                          icache_nc_i,
  input  tid_t                          icache_tid_i,
  output logic                          icache_rtrn_vld_o,
  output tid_t                          icache_rtrn_tid_o,
  output word_t [ICACHE_LINE_WORDS-1:0] icache_rtrn_data_o,
  // dcache
  input  logic                          dcache_req_i,
  output logic                          dcache_ack_o,
  input  dcache_req_e                   dcache_rtype_i,
  input  paddr_t                        dcache_paddr_i,
  input  size_t                         dcache_size_i,
  input  word_t                         dcache_data_i,
  input  tid_t                          dcache_tid_i,
  output logic                          dcache_rtrn_vld_o,
  output dcache_ack_e                   dcache_rtrn_type_o,
  output tid_t                          dcache_rtrn_tid_o,
  output word_t [DCACHE_LINE_WORDS-1:0] dcache_rtrn_data_o,
  // memory bus
  output logic                          ar_valid_o,
  input  logic                          ar_ready_i,
  output paddr_t                        ar_addr_o,
  output blen_t                         ar_len_o,
  output logic [1:0]                    ar_size_o,
  output bus_id_t                       ar_id_o,
  input  logic                          r_valid_i,
  input  word_t                         r_data_i,
  input  logic                          r_last_i,
  input  bus_id_t                       r_id_i,
  output logic                          aw_valid_o,
  input  logic                          aw_ready_i,
  output paddr_t                        aw_addr_o,
  output logic [1:0]                    aw_size_o,
  output word_t                         w_data_o,
  output strb_t                         w_strb_o,
  input  logic                          b_valid_i,
  input  bus_id_t                       b_id_i,
  output logic                          b_ready_o
);

  localparam int unsigned IcReqW = $bits(paddr_t) + 1 + $bits(tid_t);
  localparam int unsigned DcReqW = 1 + $bits(paddr_t) + $bits(size_t) + $bits(word_t)
                                   + $bits(tid_t);

  logic [IcReqW-1:0] icache_fifo_q;
  logic [DcReqW-1:0] dcache_fifo_q;
  logic   icache_req_full, icache_req_empty, dcache_req_full, dcache_req_empty;
  paddr_t icache_paddr, dcache_paddr;
  logic   icache_nc, dcache_rtype_raw;
  tid_t   icache_tid, dcache_tid;
  size_t  dcache_size;
  word_t  dcache_data;
  logic   icache_pop, dcache_pop;
  logic   icache_id_push, dcache_rd_id_push, dcache_wr_id_push;
  logic   icache_id_pop, dcache_rd_id_pop, dcache_wr_id_pop;
  logic   icache_id_full, dcache_rd_id_full, dcache_wr_id_full, dcache_wr_id_empty;
  tid_t   icache_id_tid, dcache_rd_tid, dcache_wr_tid;
  tid_t   icache_rtrn_tid_q, dcache_rtrn_tid_q;
  logic   icache_beat_en, dcache_beat_en, dcache_rtrn_is_wr;

  ////////////////////
  // request queues
  ////////////////////

  assign icache_ack_o = icache_req_i && !icache_req_full;
  assign dcache_ack_o = dcache_req_i && !dcache_req_full;

  sync_fifo #(.Width(IcReqW), .Depth(ReqFifoDepth)) i_icache_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_ack_o),
    .data_i  ({icache_paddr_i, icache_nc_i, icache_tid_i}),
    .pop_i   (icache_pop),
    .data_o  (icache_fifo_q),
    .full_o  (icache_req_full),
    .empty_o (icache_req_empty)
  );

  sync_fifo #(.Width(DcReqW), .Depth(ReqFifoDepth)) i_dcache_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_ack_o),
    .data_i  ({dcache_rtype_i, dcache_paddr_i, dcache_size_i, dcache_data_i, dcache_tid_i}),
    .pop_i   (dcache_pop),
    .data_o  (dcache_fifo_q),
    .full_o  (dcache_req_full),
    .empty_o (dcache_req_empty)
  );

  assign {icache_paddr, icache_nc, icache_tid} = icache_fifo_q;
  assign {dcache_rtype_raw, dcache_paddr, dcache_size, dcache_data, dcache_tid} = dcache_fifo_q;

  ////////////////////
  // id queues
  ////////////////////

  sync_fifo #(.Width($bits(tid_t)), .Depth(MetaFifoDepth)) i_icache_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_id_push),
    .data_i  (icache_tid),
    .pop_i   (icache_id_pop),
    .data_o  (icache_id_tid),
    .full_o  (icache_id_full),
    .empty_o ()
  );

  sync_fifo #(.Width($bits(tid_t)), .Depth(MetaFifoDepth)) i_dcache_rd_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_rd_id_push),
    .data_i  (dcache_tid),
    .pop_i   (dcache_rd_id_pop),
    .data_o  (dcache_rd_tid),
    .full_o  (dcache_rd_id_full),
    .empty_o ()
  );

  sync_fifo #(.Width($bits(tid_t)), .Depth(MetaFifoDepth)) i_dcache_wr_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_wr_id_push),
    .data_i  (dcache_tid),
    .pop_i   (dcache_wr_id_pop),
    .data_o  (dcache_wr_tid),
    .full_o  (dcache_wr_id_full),
    .empty_o (dcache_wr_id_empty)
  );

  ////////////////////
  // control
  ////////////////////

  adapter_ctrl i_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .icache_empty_i       (icache_req_empty),
    .dcache_empty_i       (dcache_req_empty),
    .icache_id_full_i     (icache_id_full),
    .dcache_rd_id_full_i  (dcache_rd_id_full),
    .dcache_wr_id_full_i  (dcache_wr_id_full),
    .dcache_wr_id_empty_i (dcache_wr_id_empty),
    .icache_paddr_i       (icache_paddr),
    .dcache_paddr_i       (dcache_paddr),
    .icache_nc_i          (icache_nc),
    .dcache_rtype_i       (dcache_req_e'(dcache_rtype_raw)),
    .dcache_size_i        (dcache_size),
    .dcache_data_i        (dcache_data),
    .icache_pop_o         (icache_pop),
    .dcache_pop_o         (dcache_pop),
    .icache_id_push_o     (icache_id_push),
    .dcache_rd_id_push_o  (dcache_rd_id_push),
    .dcache_wr_id_push_o  (dcache_wr_id_push),
    .icache_id_pop_o      (icache_id_pop),
    .dcache_rd_id_pop_o   (dcache_rd_id_pop),
    .dcache_wr_id_pop_o   (dcache_wr_id_pop),
    .ar_valid_o           (ar_valid_o),
    .ar_ready_i           (ar_ready_i),
    .ar_addr_o            (ar_addr_o),
    .ar_len_o             (ar_len_o),
    .ar_size_o            (ar_size_o),
    .ar_id_o              (ar_id_o),
    .aw_valid_o           (aw_valid_o),
    .aw_ready_i           (aw_ready_i),
    .aw_addr_o            (aw_addr_o),
    .aw_size_o            (aw_size_o),
    .w_data_o             (w_data_o),
    .w_strb_o             (w_strb_o),
    .r_valid_i            (r_valid_i),
    .r_last_i             (r_last_i),
    .r_id_i               (r_id_i),
    .b_valid_i            (b_valid_i),
    .b_id_i               (b_id_i),
    .b_ready_o            (b_ready_o),
    .icache_beat_en_o     (icache_beat_en),
    .dcache_beat_en_o     (dcache_beat_en),
    .icache_rtrn_vld_o    (icache_rtrn_vld_o),
    .dcache_rtrn_vld_o    (dcache_rtrn_vld_o),
    .dcache_rtrn_type_o   (dcache_rtrn_type_o),
    .dcache_rtrn_is_wr_o  (dcache_rtrn_is_wr)
  );

  ////////////////////
  // return path
  ////////////////////

  line_assembler #(.LineWords(ICACHE_LINE_WORDS)) i_icache_line (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .beat_en_i   (icache_beat_en),
    .beat_data_i (r_data_i),
    .beat_last_i (r_last_i),
    .line_o      (icache_rtrn_data_o)
  );

  line_assembler #(.LineWords(DCACHE_LINE_WORDS)) i_dcache_line (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .beat_en_i   (dcache_beat_en),
    .beat_data_i (r_data_i),
    .beat_last_i (r_last_i),
    .line_o      (dcache_rtrn_data_o)
  );

  // tid sampled in the pop cycle, lines up with the registered valid
  always_ff @(posedge clk_i) begin
    icache_rtrn_tid_q <= icache_id_tid;
    dcache_rtrn_tid_q <= dcache_rtrn_is_wr ? dcache_wr_tid : dcache_rd_tid;
  end

  assign icache_rtrn_tid_o = icache_rtrn_tid_q;
  assign dcache_rtrn_tid_o = dcache_rtrn_tid_q;

endmodule

`default_nettype wire

//--- tb_cache_bus_adapter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_bus_adapter import adapter_pkg::*; ();

  localparam int NUM_IC = 150;
  localparam int NUM_DC = 150;
  localparam int TIMEOUT_CYCLES = (NUM_IC + NUM_DC) * 200;
  localparam word_t MEM_MULT = 64'h9e37_79b9_7f4a_7c15;

  typedef struct packed {
    paddr_t addr;
    logic   nc;
    tid_t   tid;
  } ic_req_t;

  typedef struct packed {
    dcache_req_e rtype;
    paddr_t      addr;
    size_t       size;
    word_t       data;
    tid_t        tid;
  } dc_req_t;

  typedef struct packed {
    paddr_t  addr;
    blen_t   len;
    bus_id_t id;
  } rd_txn_t;

  logic clk_i, rst_ni;
  logic icache_req_i, icache_ack_o, icache_nc_i, icache_rtrn_vld_o;
  paddr_t icache_paddr_i;
  tid_t icache_tid_i, icache_rtrn_tid_o;
  word_t [ICACHE_LINE_WORDS-1:0] icache_rtrn_data_o;
  logic dcache_req_i, dcache_ack_o, dcache_rtrn_vld_o;
  dcache_req_e dcache_rtype_i;
  paddr_t dcache_paddr_i;
  size_t dcache_size_i;
  word_t dcache_data_i;
  tid_t dcache_tid_i, dcache_rtrn_tid_o;
  dcache_ack_e dcache_rtrn_type_o;
  word_t [DCACHE_LINE_WORDS-1:0] dcache_rtrn_data_o;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_last_i;
  paddr_t ar_addr_o, aw_addr_o;
  blen_t ar_len_o;
  logic [1:0] ar_size_o, aw_size_o;
  bus_id_t ar_id_o, r_id_i, b_id_i;
  word_t r_data_i, w_data_o;
  logic aw_valid_o, aw_ready_i, b_valid_i, b_ready_o;
  strb_t w_strb_o;

  // model and responder state
  integer seed;
  ic_req_t ic_cur, ic_pend[$], ic_out[$];
  dc_req_t dc_cur, dc_pend[$], dc_load_out[$];
  tid_t dc_store_out[$];
  rd_txn_t rd_q[$];
  int rd_beat, b_pending, ic_left, dc_left, phase_left, cycles;
  logic ic_taken, dc_taken, b_fired, stalled;
  logic ic_rtrn_due, dc_rtrn_due, dc_store_due;
  int unsigned errors, checks, accepted, returned, ack_drops;

  cache_bus_adapter #(.ReqFifoDepth(2), .MetaFifoDepth(4)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers
  ////////////////////

  // what the memory holds at a given beat
  function automatic word_t mem_word(paddr_t addr, int beat);
    return (word_t'(addr) + word_t'(beat) * 64'd8) * MEM_MULT;
  endfunction

  // strobes follow the natural alignment of the access size
  function automatic strb_t expected_strobe(paddr_t addr, size_t size);
    strb_t s;
    case (size[1:0])
      2'd0:    s = 8'h01 << addr[2:0];
      2'd1:    s = 8'h03 << (addr[2:0] & 3'b110);
      2'd2:    s = 8'h0f << (addr[2:0] & 3'b100);
      default: s = 8'hff;
    endcase
    return s;
  endfunction

  task automatic compare(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  function automatic logic all_done();
    return ic_left == 0 && dc_left == 0 && !icache_req_i && !dcache_req_i
      && ic_pend.size() == 0 && dc_pend.size() == 0 && ic_out.size() == 0
      && dc_load_out.size() == 0 && dc_store_out.size() == 0 && rd_q.size() == 0
      && b_pending == 0;
  endfunction

  ////////////////////
  // bus side model
  ////////////////////

  task automatic handle_read_addr();
    ic_req_t ic;
    dc_req_t dc;
    rd_txn_t t;
    t.addr = ar_addr_o;
    t.len = ar_len_o;
    t.id = ar_id_o;
    rd_q.push_back(t);
    if (ar_id_o == ID_ICACHE) begin
      if (ic_pend.size() == 0) begin
        report_failure("icache read on the bus with no accepted icache request");
      end else begin
        ic = ic_pend.pop_front();
        compare("icache ar_addr", word_t'(ic.addr), word_t'(ar_addr_o));
        compare("icache ar_len", ic.nc ? 64'd0 : word_t'(ICACHE_LINE_WORDS - 1),
                word_t'(ar_len_o));
        compare("icache ar_size", 64'd3, word_t'(ar_size_o));
        ic_out.push_back(ic);
      end
    end else begin
      if (dc_pend.size() == 0) begin
        report_failure("dcache read on the bus with no accepted dcache request");
      end else begin
        dc = dc_pend.pop_front();
        compare("dcache read is a load", word_t'(DCACHE_LOAD), word_t'(dc.rtype));
        compare("dcache ar_addr", word_t'(dc.addr), word_t'(ar_addr_o));
        compare("dcache ar_len", dc.size[2] ? word_t'(DCACHE_LINE_WORDS - 1) : 64'd0,
                word_t'(ar_len_o));
        compare("dcache ar_size", word_t'(dc.size[1:0]), word_t'(ar_size_o));
        dc_load_out.push_back(dc);
      end
    end
  endtask

  task automatic handle_write();
    dc_req_t dc;
    if (dc_pend.size() == 0) begin
      report_failure("write on the bus with no accepted dcache request");
    end else begin
      dc = dc_pend.pop_front();
      compare("dcache write is a store", word_t'(DCACHE_STORE), word_t'(dc.rtype));
      compare("aw_addr", word_t'(dc.addr), word_t'(aw_addr_o));
      compare("aw_size", word_t'(dc.size[1:0]), word_t'(aw_size_o));
      compare("w_data", dc.data, w_data_o);
      compare("w_strb", word_t'(expected_strobe(dc.addr, dc.size)), word_t'(w_strb_o));
      compare("to_byte_enable", word_t'(expected_strobe(dc.addr, dc.size)),
              word_t'(to_byte_enable(dc.addr[2:0], dc.size[1:0])));
      dc_store_out.push_back(dc.tid);
    end
    b_pending++;
  endtask

  ////////////////////
  // return checks
  ////////////////////

  task automatic check_icache_return();
    ic_req_t ic;
    int words;
    if (ic_out.size() == 0) begin
      report_failure("icache return with no outstanding refill");
    end else begin
      ic = ic_out.pop_front();
      words = ic.nc ? 1 : ICACHE_LINE_WORDS;
      compare("icache return tid", word_t'(ic.tid), word_t'(icache_rtrn_tid_o));
      for (int k = 0; k < words; k++) begin
        compare("icache return data", mem_word(ic.addr, k), icache_rtrn_data_o[k]);
      end
      returned++;
    end
  endtask

  task automatic check_dcache_return();
    dc_req_t dc;
    tid_t t;
    int words;
    if (dc_store_due) begin
      compare("dcache return type", word_t'(DCACHE_STORE_ACK), word_t'(dcache_rtrn_type_o));
      if (dc_store_out.size() == 0) begin
        report_failure("store acknowledge with no outstanding store");
      end else begin
        t = dc_store_out.pop_front();
        compare("store ack tid", word_t'(t), word_t'(dcache_rtrn_tid_o));
        returned++;
      end
    end else begin
      compare("dcache return type", word_t'(DCACHE_LOAD_ACK), word_t'(dcache_rtrn_type_o));
      if (dc_load_out.size() == 0) begin
        report_failure("load acknowledge with no outstanding load");
      end else begin
        dc = dc_load_out.pop_front();
        words = dc.size[2] ? DCACHE_LINE_WORDS : 1;
        compare("load ack tid", word_t'(dc.tid), word_t'(dcache_rtrn_tid_o));
        for (int k = 0; k < words; k++) begin
          compare("load ack data", mem_word(dc.addr, k), dcache_rtrn_data_o[k]);
        end
        returned++;
      end
    end
  endtask

  // values are stable here since the falling edge
  task automatic observe_edge();
    // a return is due one cycle after its last beat or write response
    compare("icache_rtrn_vld timing", word_t'(ic_rtrn_due), word_t'(icache_rtrn_vld_o));
    compare("dcache_rtrn_vld timing", word_t'(dc_rtrn_due), word_t'(dcache_rtrn_vld_o));
    if (icache_rtrn_vld_o) check_icache_return();
    if (dcache_rtrn_vld_o) check_dcache_return();
    ic_rtrn_due = r_valid_i && r_last_i && (r_id_i == ID_ICACHE);
    dc_store_due = b_valid_i && b_ready_o;
    dc_rtrn_due = (r_valid_i && r_last_i && (r_id_i == ID_DCACHE)) || dc_store_due;
    if (icache_req_i) begin
      if (icache_ack_o) begin
        ic_pend.push_back(ic_cur);
        ic_taken = 1'b1;
        accepted++;
      end else begin
        ack_drops++;
      end
    end
    if (dcache_req_i) begin
      if (dcache_ack_o) begin
        dc_pend.push_back(dc_cur);
        dc_taken = 1'b1;
        accepted++;
      end else begin
        ack_drops++;
      end
    end
    if (ar_valid_o && ar_ready_i) handle_read_addr();
    if (aw_valid_o && aw_ready_i) handle_write();
    if (r_valid_i) begin
      if (r_last_i) begin
        rd_q.delete(0);
        rd_beat = 0;
      end else begin
        rd_beat++;
      end
    end
    if (b_valid_i && b_ready_o) begin
      b_pending--;
      b_fired = 1'b1;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic new_icache_request();
    paddr_t a;
    a = $random(seed);
    a[2:0] = 3'b000;
    ic_cur.addr = a;
    ic_cur.nc = ({$random(seed)} % 4) == 0;
    ic_cur.tid = tid_t'($random(seed));
    icache_req_i = 1'b1;
    icache_paddr_i = ic_cur.addr;
    icache_nc_i = ic_cur.nc;
    icache_tid_i = ic_cur.tid;
    ic_left--;
  endtask

  task automatic new_dcache_request();
    dc_cur.rtype = (({$random(seed)} % 2) == 0) ? DCACHE_LOAD : DCACHE_STORE;
    dc_cur.addr = $random(seed);
    dc_cur.size = size_t'($random(seed));
    // stores are single words
    if (dc_cur.rtype == DCACHE_STORE) dc_cur.size[2] = 1'b0;
    dc_cur.data = {$random(seed), $random(seed)};
    dc_cur.tid = tid_t'($random(seed));
    dcache_req_i = 1'b1;
    dcache_rtype_i = dc_cur.rtype;
    dcache_paddr_i = dc_cur.addr;
    dcache_size_i = dc_cur.size;
    dcache_data_i = dc_cur.data;
    dcache_tid_i = dc_cur.tid;
    dc_left--;
  endtask

  task automatic drive_inputs();
    if (ic_taken) begin
      icache_req_i = 1'b0;
      ic_taken = 1'b0;
    end
    if (!icache_req_i && ic_left > 0 && ({$random(seed)} % 3) != 0) new_icache_request();
    if (dc_taken) begin
      dcache_req_i = 1'b0;
      dc_taken = 1'b0;
    end
    if (!dcache_req_i && dc_left > 0 && ({$random(seed)} % 3) != 0) new_dcache_request();
    // ready comes in phases and some of them are fully stalled
    if (phase_left == 0) begin
      stalled = ({$random(seed)} % 3) == 0;
      phase_left = 20 + {$random(seed)} % 60;
    end else begin
      phase_left--;
    end
    ar_ready_i = !stalled && (({$random(seed)} % 2) == 0);
    aw_ready_i = !stalled && (({$random(seed)} % 2) == 0);
    // read beats go out in issue order with random gaps
    r_valid_i = 1'b0;
    r_last_i = 1'b0;
    if (rd_q.size() > 0 && ({$random(seed)} % 4) != 0) begin
      r_valid_i = 1'b1;
      r_id_i = rd_q[0].id;
      r_data_i = mem_word(rd_q[0].addr, rd_beat);
      r_last_i = (rd_beat == int'(rd_q[0].len));
    end
    if (b_fired) begin
      b_valid_i = 1'b0;
      b_fired = 1'b0;
    end
    if (!b_valid_i && b_pending > 0 && ({$random(seed)} % 4) == 0) begin
      b_valid_i = 1'b1;
      b_id_i = ID_DCACHE;
    end
  endtask

  initial begin : stimulus
    seed = 32'hae5d9813;
    {icache_req_i, icache_nc_i, dcache_req_i, ar_ready_i, aw_ready_i} = '0;
    {r_valid_i, r_last_i, r_id_i, b_valid_i, b_id_i} = '0;
    icache_paddr_i = '0;
    icache_tid_i = '0;
    dcache_rtype_i = DCACHE_LOAD;
    dcache_paddr_i = '0;
    dcache_size_i = '0;
    dcache_data_i = '0;
    dcache_tid_i = '0;
    r_data_i = '0;
    {ic_taken, dc_taken, b_fired, stalled} = '0;
    {ic_rtrn_due, dc_rtrn_due, dc_store_due} = '0;
    rd_beat = 0;
    b_pending = 0;
    phase_left = 0;
    ic_left = NUM_IC;
    dc_left = NUM_DC;
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    // nothing is requested yet so the bus and return side stay quiet
    repeat (6) begin
      @(posedge clk_i);
      compare("idle ar_valid", 64'd0, word_t'(ar_valid_o));
      compare("idle aw_valid", 64'd0, word_t'(aw_valid_o));
      compare("idle icache_rtrn_vld", 64'd0, word_t'(icache_rtrn_vld_o));
      compare("idle dcache_rtrn_vld", 64'd0, word_t'(dcache_rtrn_vld_o));
      compare("idle acks", 64'd0, word_t'({icache_ack_o, dcache_ack_o}));
      compare("idle b_ready", 64'd0, word_t'(b_ready_o));
    end
    while (!all_done()) begin
      @(posedge clk_i);
      observe_edge();
      @(negedge clk_i);
      drive_inputs();
    end
    // a late duplicate return would show up while draining
    repeat (20) begin
      @(posedge clk_i);
      observe_edge();
      @(negedge clk_i);
      drive_inputs();
    end
    compare("every accepted tid returned once", word_t'(accepted), word_t'(returned));
    compare("acks dropped under back-pressure", 64'd1, word_t'(ack_drops > 0));
    $display("checks: %0d, errors: %0d, accepted: %0d, returned: %0d",
             checks, errors, accepted, returned);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d, accepted: %0d, returned: %0d",
             checks, errors, accepted, returned);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
adapter_pkg.sv
sync_fifo.sv
line_assembler.sv
adapter_ctrl.sv
cache_bus_adapter.sv
tb_cache_bus_adapter.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_bus_adapter
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/100ps

.PHONY: sim clean

# build, run, and pass only when the pass line appears
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
